/* hw/videoPkg.sv */
`default_nettype none

package videoPkg;

	localparam int ScreenW = 640;
	localparam int ScreenH = 480;
	typedef logic [9:0] PixCoord;

	// Overworld map texel grid
	localparam int MapW = 128;
	localparam int MapH = 96;
	localparam int MapScale = 4;

	// Start image texel grid
	localparam int StartW = 160;
	localparam int StartH = 120;
	localparam int StartScale = 4;

	// Sprite sheet and the fixed sprite box on screen
	localparam int SheetW = 228;
	localparam int SpriteW = 19;
	localparam int SpriteH = 29;
	localparam int SpriteX0 = 311;
	localparam int SpriteY0 = 340;

	typedef logic [13:0] MapAddr;
	typedef logic [14:0] StartAddr;
	typedef logic [12:0] SheetAddr;
	typedef logic [7:0] PalAddr;

	typedef logic [7:0] PalIndex;
	typedef logic [3:0] SpriteIndex;
	typedef logic [23:0] Rgb;

	// Sprite colours sit at the top of the palette
	localparam int SpritePalBase = 240;

	typedef enum logic [1:0] {assetMap, assetSheet, assetStart, assetPalette} AssetSel;
	localparam int AssetAddrW = 15;

endpackage

`default_nettype wire

/* hw/gamePkg.sv */
`default_nettype none

package gamePkg;

	typedef enum logic {modeStart, modeOverworld} GameMode;

	typedef enum logic [1:0] {
		dirUp = 2'd0,
		dirRight = 2'd1,
		dirDown = 2'd2,
		dirLeft = 2'd3
	} Dir;

	// Walk cycle with a rest frame between the stride frames
	typedef enum logic [1:0] {rest1, move1, rest2, move2} WalkPhase;

	localparam logic [7:0] KeyStart = 8'h2C;

	typedef logic signed [11:0] CamCoord;

	localparam CamCoord CamStartX = 12'sd100;
	localparam CamCoord CamStartY = 12'sd100;

	// Inclusive camera range
	localparam CamCoord CamMinX = -12'sd310;
	localparam CamCoord CamMaxX = 12'sd952;
	localparam CamCoord CamMinY = -12'sd339;
	localparam CamCoord CamMaxY = 12'sd595;

	// Frame ticks per animation step
	localparam int StepTicks = 8;

	// Sheet column of each frame by direction then phase
	localparam logic [7:0] FrameOffset [4][4] = '{
		'{8'd133, 8'd114, 8'd133, 8'd152},
		'{8'd190, 8'd171, 8'd190, 8'd209},
		'{8'd19, 8'd0, 8'd19, 8'd38},
		'{8'd76, 8'd57, 8'd76, 8'd95}
	};

endpackage

`default_nettype wire

/* hw/assetMemory.sv */
`timescale 1ns/10ps
`default_nettype none

module assetMemory #(
	parameter int Depth = 256,
	parameter int Width = 8
) (
	input logic Clk,
	input logic We,
	input logic [$clog2(Depth)-1:0] WrAddr,
	input logic [Width-1:0] WrData,
	input logic [$clog2(Depth)-1:0] RdAddr,
	output logic [Width-1:0] RdData
);

	logic [Width-1:0] mem [Depth];

	always_ff @(posedge Clk) begin
		if (We) begin
			mem[WrAddr] <= WrData;
		end
		RdData <= mem[RdAddr];
	end

endmodule

`default_nettype wire

/* hw/assetLoader.sv */
`timescale 1ns/10ps
`default_nettype none

module assetLoader import videoPkg::*; (
	input logic Clk,
	input logic rst,
	input logic AssetReq,
	input videoPkg::AssetSel AssetSel,
	output logic AssetAck,
	output logic MapWe,
	output logic SheetWe,
	output logic StartWe,
	output logic PalWe
);

	typedef enum logic [1:0] {loadIdle, loadWrite, loadAck} LoadState;

	LoadState state;
	logic writing;

	always_ff @(posedge Clk) begin
		if (rst) begin
			state <= loadIdle;
		end else begin
			case (state)
				loadIdle: begin
					if (AssetReq) begin
						state <= loadWrite;
					end
				end
				loadWrite: begin
					state <= loadAck;
				end
				default: begin
					// Hold ack until the requester lets go
					if (!AssetReq) begin
						state <= loadIdle;
					end
				end
			endcase
		end
	end

	assign writing = (state == loadWrite);
	assign AssetAck = (state == loadAck);

	assign MapWe = writing && (AssetSel == assetMap);
	assign SheetWe = writing && (AssetSel == assetSheet);
	assign StartWe = writing && (AssetSel == assetStart);
	assign PalWe = writing && (AssetSel == assetPalette);

endmodule

`default_nettype wire

/* hw/walkController.sv */
`timescale 1ns/10ps
`default_nettype none

module walkController import gamePkg::*; (
	input logic Clk,
	input logic rst,
	input logic FrameTick,
	input logic [7:0] Keycode,
	input logic Moving,
	input Dir Direction,
	output GameMode Mode,
	output Dir Facing,
	output WalkPhase Phase,
	output CamCoord CameraX,
	output CamCoord CameraY
);

	logic [$clog2(StepTicks)-1:0] stepCount;
	logic startGame;
	logic walking;
	logic stepping;

	assign startGame = FrameTick && (Mode == modeStart) && (Keycode == KeyStart);
	assign walking = FrameTick && (Mode == modeOverworld);

	// A step only when already facing the way we move
	assign stepping = walking && Moving && (Direction == Facing);

	always_ff @(posedge Clk) begin
		if (rst) begin
			Mode <= modeStart;
		end else if (startGame) begin
			Mode <= modeOverworld;
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			Facing <= dirUp;
			Phase <= rest1;
			stepCount <= '0;
		end else if (walking) begin
			if (!Moving) begin
				Phase <= rest1;
			end else if (Direction != Facing) begin
				// Turn in place
				Facing <= Direction;
				Phase <= rest1;
			end else begin
				if (stepCount == ($clog2(StepTicks))'(StepTicks - 1)) begin
					stepCount <= '0;
				end else begin
					stepCount <= stepCount + 1'b1;
				end
				if (stepCount == '0) begin
					Phase <= WalkPhase'(Phase + 2'd1);
				end
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (rst) begin
			CameraX <= '0;
			CameraY <= '0;
		end else if (startGame) begin
			CameraX <= CamStartX;
			CameraY <= CamStartY;
		end else if (stepping) begin
			case (Facing)
				dirUp: begin
					if (CameraY > CamMinY) begin
						CameraY <= CameraY - 12'sd1;
					end
				end
				dirDown: begin
					if (CameraY < CamMaxY) begin
						CameraY <= CameraY + 12'sd1;
					end
				end
				dirLeft: begin
					if (CameraX > CamMinX) begin
						CameraX <= CameraX - 12'sd1;
					end
				end
				default: begin
					if (CameraX < CamMaxX) begin
						CameraX <= CameraX + 12'sd1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/pixelAddressGen.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelAddressGen
	import videoPkg::*;
	import gamePkg::*;
(
	input logic Clk,
	input logic rst,
	input PixCoord DrawX,
	input PixCoord DrawY,
	input logic DisplayEnable,
	input GameMode Mode,
	input Dir Facing,
	input WalkPhase Phase,
	input CamCoord CameraX,
	input CamCoord CameraY,
	output MapAddr MapRdAddr,
	output SheetAddr SheetRdAddr,
	output StartAddr StartRdAddr,
	output logic InSprite,
	output logic MapInside,
	output GameMode ModeD,
	output logic EnableD
);

	CamCoord worldX;
	CamCoord worldY;
	logic overworld;
	logic onScreen;
	logic inSpriteC;
	logic mapInsideC;

	// World position under the current pixel
	assign worldX = CamCoord'({2'b00, DrawX}) + CameraX;
	assign worldY = CamCoord'({2'b00, DrawY}) + CameraY;

	assign overworld = (Mode == modeOverworld);
	assign onScreen = (DrawX < ScreenW) && (DrawY < ScreenH);

	assign mapInsideC = (worldX >= 0) && (worldX < MapW * MapScale) &&
		(worldY >= 0) && (worldY < MapH * MapScale);

	assign inSpriteC = (DrawX >= SpriteX0) && (DrawX < SpriteX0 + SpriteW) &&
		(DrawY >= SpriteY0) && (DrawY < SpriteY0 + SpriteH);

	always_comb begin
		MapRdAddr = '0;
		SheetRdAddr = '0;
		StartRdAddr = '0;
		if (overworld && mapInsideC) begin
			MapRdAddr = MapAddr'((int'(worldY) / MapScale) * MapW + int'(worldX) / MapScale);
		end
		if (overworld && inSpriteC) begin
			SheetRdAddr = SheetAddr'(SheetW * (int'(DrawY) - SpriteY0) +
				(int'(DrawX) - SpriteX0) + int'(FrameOffset[Facing][Phase]));
		end
		if (!overworld && onScreen) begin
			StartRdAddr = StartAddr'((int'(DrawY) / StartScale) * StartW +
				int'(DrawX) / StartScale);
		end
	end

	// Flags travel alongside the memory read
	always_ff @(posedge Clk) begin
		if (rst) begin
			InSprite <= 1'b0;
			MapInside <= 1'b0;
			ModeD <= modeStart;
			EnableD <= 1'b0;
		end else begin
			InSprite <= inSpriteC;
			MapInside <= mapInsideC;
			ModeD <= Mode;
			EnableD <= DisplayEnable;
		end
	end

endmodule

`default_nettype wire

/* hw/pixelCompositor.sv */
`timescale 1ns/10ps
`default_nettype none

module pixelCompositor
	import videoPkg::*;
	import gamePkg::*;
(
	input logic Clk,
	input logic rst,
	input logic InSprite,
	input logic MapInside,
	input GameMode ModeD,
	input logic EnableD,
	input PalIndex MapData,
	input SpriteIndex SheetData,
	input PalIndex StartData,
	output PalAddr PalRdAddr,
	input Rgb PalData,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue
);

	logic blackC;
	logic blackD;

	always_comb begin
		if (ModeD == modeStart) begin
			PalRdAddr = PalAddr'(StartData);
		end else if (InSprite && (SheetData != '0)) begin
			// Sprite index 0 is transparent
			PalRdAddr = PalAddr'(SpritePalBase + int'(SheetData));
		end else begin
			PalRdAddr = PalAddr'(MapData);
		end
	end

	assign blackC = !EnableD || ((ModeD == modeOverworld) && !MapInside);

	// Black flag lines up with the palette output
	always_ff @(posedge Clk) begin
		if (rst) begin
			blackD <= 1'b1;
			{Red, Green, Blue} <= '0;
		end else begin
			blackD <= blackC;
			{Red, Green, Blue} <= blackD ? Rgb'(0) : PalData;
		end
	end

endmodule

`default_nettype wire

/* hw/colorMapper.sv */
`timescale 1ns/10ps
`default_nettype none

module colorMapper
	import videoPkg::*;
	import gamePkg::*;
(
	input logic Clk,
	input logic rst,
	input logic FrameTick,
	input logic DisplayEnable,
	input PixCoord DrawX,
	input PixCoord DrawY,
	input logic [7:0] Keycode,
	input logic Moving,
	input Dir Direction,
	input logic AssetReq,
	input videoPkg::AssetSel AssetSel,
	input logic [AssetAddrW-1:0] AssetAddr,
	input Rgb AssetData,
	output logic AssetAck,
	output logic [7:0] Red,
	output logic [7:0] Green,
	output logic [7:0] Blue,
	output GameMode Mode,
	output CamCoord CameraX,
	output CamCoord CameraY
);

	logic mapWe;
	logic sheetWe;
	logic startWe;
	logic palWe;
	Dir facing;
	WalkPhase phase;
	MapAddr mapRdAddr;
	SheetAddr sheetRdAddr;
	StartAddr startRdAddr;
	PalAddr palRdAddr;
	PalIndex mapData;
	SpriteIndex sheetData;
	PalIndex startData;
	Rgb palData;
	logic inSprite;
	logic mapInside;
	GameMode modeD;
	logic enableD;

	assetLoader loader (
		.Clk(Clk),
		.rst(rst),
		.AssetReq(AssetReq),
		.AssetSel(AssetSel),
		.AssetAck(AssetAck),
		.MapWe(mapWe),
		.SheetWe(sheetWe),
		.StartWe(startWe),
		.PalWe(palWe)
	);

	walkController walker (
		.Clk(Clk),
		.rst(rst),
		.FrameTick(FrameTick),
		.Keycode(Keycode),
		.Moving(Moving),
		.Direction(Direction),
		.Mode(Mode),
		.Facing(facing),
		.Phase(phase),
		.CameraX(CameraX),
		.CameraY(CameraY)
	);

	pixelAddressGen addrGen (
		.Clk(Clk),
		.rst(rst),
		.DrawX(DrawX),
		.DrawY(DrawY),
		.DisplayEnable(DisplayEnable),
		.Mode(Mode),
		.Facing(facing),
		.Phase(phase),
		.CameraX(CameraX),
		.CameraY(CameraY),
		.MapRdAddr(mapRdAddr),
		.SheetRdAddr(sheetRdAddr),
		.StartRdAddr(startRdAddr),
		.InSprite(inSprite),
		.MapInside(mapInside),
		.ModeD(modeD),
		.EnableD(enableD)
	);

	// Narrow memories take the low bits of the load data
	assetMemory #(.Depth(MapW * MapH), .Width($bits(PalIndex))) mapMem (
		.Clk(Clk),
		.We(mapWe),
		.WrAddr(AssetAddr[$bits(MapAddr)-1:0]),
		.WrData(AssetData[$bits(PalIndex)-1:0]),
		.RdAddr(mapRdAddr),
		.RdData(mapData)
	);

	assetMemory #(.Depth(SheetW * SpriteH), .Width($bits(SpriteIndex))) sheetMem (
		.Clk(Clk),
		.We(sheetWe),
		.WrAddr(AssetAddr[$bits(SheetAddr)-1:0]),
		.WrData(AssetData[$bits(SpriteIndex)-1:0]),
		.RdAddr(sheetRdAddr),
		.RdData(sheetData)
	);

	assetMemory #(.Depth(StartW * StartH), .Width($bits(PalIndex))) startMem (
		.Clk(Clk),
		.We(startWe),
		.WrAddr(AssetAddr[$bits(StartAddr)-1:0]),
		.WrData(AssetData[$bits(PalIndex)-1:0]),
		.RdAddr(startRdAddr),
		.RdData(startData)
	);

	assetMemory #(.Depth(2 ** $bits(PalAddr)), .Width($bits(Rgb))) palMem (
		.Clk(Clk),
		.We(palWe),
		.WrAddr(AssetAddr[$bits(PalAddr)-1:0]),
		.WrData(AssetData),
		.RdAddr(palRdAddr),
		.RdData(palData)
	);

	pixelCompositor compositor (
		.Clk(Clk),
		.rst(rst),
		.InSprite(inSprite),
		.MapInside(mapInside),
		.ModeD(modeD),
		.EnableD(enableD),
		.MapData(mapData),
		.SheetData(sheetData),
		.StartData(startData),
		.PalRdAddr(palRdAddr),
		.PalData(palData),
		.Red(Red),
		.Green(Green),
		.Blue(Blue)
	);

endmodule

`default_nettype wire

/* tests/clockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int Period = 4,
	parameter int ResetCycles = 10
) (
	output logic Clk,
	output logic rst
);

	initial begin
		Clk = 1'b0;
		forever #(Period / 2) Clk = ~Clk;
	end

	// Reset released on a rising edge
	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge Clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tests/colorMapperTb.sv */
`timescale 1ns/10ps
`default_nettype none

module colorMapperTb
	import videoPkg::*;
	import gamePkg::*;
();

	localparam int GoldenDepth = 64;
	localparam int AckTimeout = 20;
	localparam int ResetTimeout = 50;

	logic Clk;
	logic rst;
	logic frameTick;
	logic displayEnable;
	PixCoord drawX;
	PixCoord drawY;
	logic [7:0] keycode;
	logic moving;
	Dir direction;
	logic assetReq;
	AssetSel assetSel;
	logic [AssetAddrW-1:0] assetAddr;
	Rgb assetData;
	logic assetAck;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	GameMode mode;
	CamCoord cameraX;
	CamCoord cameraY;

	int errors;
	int timeouts;
	logic aborted;
	logic [15:0] lfsrState;
	logic [47:0] golden [GoldenDepth];

	// Mirrors of the loaded assets
	PalIndex mapMirror [MapW * MapH];
	SpriteIndex sheetMirror [SheetW * SpriteH];
	PalIndex startMirror [StartW * StartH];
	Rgb palMirror [256];

	// Reference walk state
	GameMode mMode;
	Dir mFacing;
	WalkPhase mPhase;
	int mCount;
	CamCoord mCamX;
	CamCoord mCamY;

	clockGen #(.Period(4), .ResetCycles(10)) clocks (
		.Clk(Clk),
		.rst(rst)
	);

	colorMapper dut_i (
		.Clk(Clk),
		.rst(rst),
		.FrameTick(frameTick),
		.DisplayEnable(displayEnable),
		.DrawX(drawX),
		.DrawY(drawY),
		.Keycode(keycode),
		.Moving(moving),
		.Direction(direction),
		.AssetReq(assetReq),
		.AssetSel(assetSel),
		.AssetAddr(assetAddr),
		.AssetData(assetData),
		.AssetAck(assetAck),
		.Red(red),
		.Green(green),
		.Blue(blue),
		.Mode(mode),
		.CameraX(cameraX),
		.CameraY(cameraY)
	);

	task automatic checkRgb(input string name, input Rgb expected, input Rgb actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %0t %s expected %06h actual %06h", $time, name, expected, actual);
		end
	endtask

	task automatic checkCamera(input string name, input CamCoord expected, input CamCoord actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic checkMode(input string name, input GameMode expected, input GameMode actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR %0t %s expected %s actual %s", $time, name, expected.name(),
				actual.name());
		end
	endtask

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic randomBits(input int n, output Rgb value);
		int b;
		value = '0;
		for (b = 0; b < n; b++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[22:0], lfsrState[0]};
		end
	endtask

	task automatic waitAck(input logic level);
		int cycles;
		cycles = 0;
		@(negedge Clk);
		while (assetAck !== level && cycles < AckTimeout) begin
			@(negedge Clk);
			cycles++;
		end
		if (assetAck !== level) begin
			$display("Timed out at %0t waiting for AssetAck to go to %0b", $time, level);
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0 && cycles < ResetTimeout) begin
			@(negedge Clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			$display("Timed out waiting for reset to be released");
			timeouts++;
			aborted = 1'b1;
		end
	endtask

	task automatic loadWord(input AssetSel sel, input int addr, input Rgb data);
		@(posedge Clk);
		assetSel <= sel;
		assetAddr <= addr[AssetAddrW-1:0];
		assetData <= data;
		assetReq <= 1'b1;
		waitAck(1'b1);
		if (!aborted) begin
			@(posedge Clk);
			assetReq <= 1'b0;
			// Ack holds until the loader has seen the request drop
			@(negedge Clk);
			if (assetAck !== 1'b1) begin
				$display("AssetAck fell at %0t before the loader saw AssetReq drop", $time);
				errors++;
			end
			waitAck(1'b0);
		end
	endtask

	task automatic loadAssets();
		int a;
		Rgb v;
		for (a = 0; a < 256 && !aborted; a++) begin
			randomBits(24, v);
			palMirror[a] = v;
			loadWord(assetPalette, a, v);
		end
		for (a = 0; a < MapW * MapH && !aborted; a++) begin
			randomBits(8, v);
			mapMirror[a] = v[7:0];
			loadWord(assetMap, a, v);
		end
		for (a = 0; a < SheetW * SpriteH && !aborted; a++) begin
			randomBits(4, v);
			sheetMirror[a] = v[3:0];
			loadWord(assetSheet, a, v);
		end
		for (a = 0; a < StartW * StartH && !aborted; a++) begin
			randomBits(8, v);
			startMirror[a] = v[7:0];
			loadWord(assetStart, a, v);
		end
	endtask

	function automatic WalkPhase nextPhase(input WalkPhase p);
		case (p)
			rest1: return move1;
			move1: return rest2;
			rest2: return move2;
			default: return rest1;
		endcase
	endfunction

	// Sheet column from the direction block plus the frame step
	function automatic int frameColumn(input Dir d, input WalkPhase p);
		int base;
		int step;
		case (d)
			dirDown: base = 0;
			dirLeft: base = 57;
			dirUp: base = 114;
			default: base = 171;
		endcase
		case (p)
			move1: step = 0;
			move2: step = 38;
			default: step = 19;
		endcase
		return base + step;
	endfunction

	task automatic stepModel(input logic [7:0] key, input logic move, input Dir dir);
		if (mMode == modeStart) begin
			if (key == 8'h2C) begin
				mMode = modeOverworld;
				mCamX = 12'sd100;
				mCamY = 12'sd100;
			end
		end else if (!move) begin
			mPhase = rest1;
		end else if (dir != mFacing) begin
			mFacing = dir;
			mPhase = rest1;
		end else begin
			if (mCount == 0) begin
				mPhase = nextPhase(mPhase);
			end
			mCount = (mCount + 1) % 8;
			case (mFacing)
				dirUp: mCamY = (mCamY > -12'sd339) ? mCamY - 12'sd1 : mCamY;
				dirDown: mCamY = (mCamY < 12'sd595) ? mCamY + 12'sd1 : mCamY;
				dirLeft: mCamX = (mCamX > -12'sd310) ? mCamX - 12'sd1 : mCamX;
				default: mCamX = (mCamX < 12'sd952) ? mCamX + 12'sd1 : mCamX;
			endcase
		end
	endtask

	task automatic tickOnce(input logic [7:0] key, input logic move, input Dir dir);
		@(posedge Clk);
		frameTick <= 1'b1;
		keycode <= key;
		moving <= move;
		direction <= dir;
		@(posedge Clk);
		frameTick <= 1'b0;
		keycode <= 8'h00;
		moving <= 1'b0;
		stepModel(key, move, dir);
	endtask

	function automatic Rgb expectedPixel(input int px, input int py, input logic en);
		int wx;
		int wy;
		SpriteIndex s;
		if (!en) begin
			return Rgb'(0);
		end
		if (mMode == modeStart) begin
			return palMirror[startMirror[(py / 4) * 160 + px / 4]];
		end
		wx = px + int'(mCamX);
		wy = py + int'(mCamY);
		if (wx < 0 || wx >= 512 || wy < 0 || wy >= 384) begin
			return Rgb'(0);
		end
		if (px >= 311 && px < 330 && py >= 340 && py < 369) begin
			s = sheetMirror[228 * (py - 340) + (px - 311) + frameColumn(mFacing, mPhase)];
			// Index 0 lets the map show through
			if (s != 4'd0) begin
				return palMirror[240 + int'(s)];
			end
		end
		return palMirror[mapMirror[(wy / 4) * 128 + wx / 4]];
	endfunction

	// One pixel per clock with each result due three edges later
	task automatic scanRegion(input int x0, input int y0, input int w, input int h,
		input int stride, input logic en);
		Rgb expQ [$];
		int xQ [$];
		int yQ [$];
		int cols;
		int n;
		int k;
		int px;
		int py;
		cols = (w + stride - 1) / stride;
		n = cols * ((h + stride - 1) / stride);
		for (k = 0; k < n + 3; k++) begin
			@(posedge Clk);
			if (k < n) begin
				px = x0 + (k % cols) * stride;
				py = y0 + (k / cols) * stride;
				drawX <= PixCoord'(px);
				drawY <= PixCoord'(py);
				displayEnable <= en;
				expQ.push_back(expectedPixel(px, py, en));
				xQ.push_back(px);
				yQ.push_back(py);
			end
			@(negedge Clk);
			if (k >= 3) begin
				checkRgb($sformatf("RGB at (%0d,%0d)", xQ.pop_front(), yQ.pop_front()),
					expQ.pop_front(), {red, green, blue});
			end
		end
	endtask

	task automatic scanScreen();
		scanRegion(0, 0, ScreenW, ScreenH, 37, 1'b1);
		scanRegion(SpriteX0 - 2, SpriteY0 - 2, SpriteW + 4, SpriteH + 4, 1, 1'b1);
		scanRegion(3, 5, ScreenW - 3, ScreenH - 5, 53, 1'b0);
	endtask

	task automatic runGolden();
		int i;
		int t;
		int count;
		logic [47:0] g;
		for (i = 0; i < GoldenDepth; i++) begin
			g = golden[i];
			if (g[47:44] == 4'h0) begin
				break;
			end
			count = int'(g[39:24]);
			case (g[47:44])
				4'h1: tickOnce(g[31:24], 1'b0, dirUp);
				4'h2: begin
					for (t = 0; t < count; t++) begin
						tickOnce(8'h00, 1'b1, Dir'(g[41:40]));
					end
				end
				4'h3: begin
					for (t = 0; t < count; t++) begin
						tickOnce(8'h00, 1'b0, dirUp);
					end
				end
				4'h4: begin
					@(negedge Clk);
					checkMode("Mode", GameMode'(g[24]), mode);
					checkMode("reference Mode", GameMode'(g[24]), mMode);
				end
				4'h5: begin
					@(negedge Clk);
					checkCamera("CameraX", CamCoord'(g[23:12]), cameraX);
					checkCamera("CameraY", CamCoord'(g[11:0]), cameraY);
					checkCamera("reference CameraX", CamCoord'(g[23:12]), mCamX);
					checkCamera("reference CameraY", CamCoord'(g[11:0]), mCamY);
				end
				4'h6: scanScreen();
				default: begin
					$display("Golden file line %0d holds an unknown command %h", i, g[47:44]);
					errors++;
				end
			endcase
		end
	endtask

	task automatic finishRun();
		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	endtask

	initial begin
		int i;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		lfsrState = 16'd22836;
		mMode = modeStart;
		mFacing = dirUp;
		mPhase = rest1;
		mCount = 0;
		mCamX = '0;
		mCamY = '0;
		frameTick = 1'b0;
		displayEnable = 1'b0;
		drawX = '0;
		drawY = '0;
		keycode = 8'h00;
		moving = 1'b0;
		direction = dirUp;
		assetReq = 1'b0;
		assetSel = assetMap;
		assetAddr = '0;
		assetData = '0;
		for (i = 0; i < GoldenDepth; i++) begin
			golden[i] = '0;
		end
		$readmemh("tests/colorMapperGolden.txt", golden);
		waitReset();
		if (!aborted) begin
			loadAssets();
		end
		if (!aborted) begin
			runGolden();
		end
		finishRun();
	end

endmodule

`default_nettype wire

/* tests/colorMapperGolden.txt */
// op_dir_count_camX_camY in hex, camera values 12-bit two's complement
// op 1 key tick (count = keycode), 2 move, 3 idle, 4 expect mode, 5 expect camera, 6 scan, 0 end
4_0_0000_000_000
5_0_0000_000_000
6_0_0000_000_000
1_0_001A_000_000
4_0_0000_000_000
1_0_002C_000_000
4_0_0001_000_000
5_0_0000_064_064
6_0_0000_000_000
2_1_0001_000_000
5_0_0000_064_064
2_1_0005_000_000
5_0_0000_069_064
6_0_0000_000_000
2_2_0003_000_000
5_0_0000_069_066
2_3_01F4_000_000
5_0_0000_ECA_066
6_0_0000_000_000
2_0_0258_000_000
5_0_0000_ECA_EAD
3_0_0003_000_000
1_0_002C_000_000
4_0_0001_000_000
5_0_0000_ECA_EAD
6_0_0000_000_000
2_1_0514_000_000
5_0_0000_3B8_EAD
2_2_03E8_000_000
5_0_0000_3B8_253
6_0_0000_000_000
0_0_0000_000_000

/* sources.f */
hw/videoPkg.sv
hw/gamePkg.sv
hw/assetMemory.sv
hw/assetLoader.sv
hw/walkController.sv
hw/pixelAddressGen.sv
hw/pixelCompositor.sv
hw/colorMapper.sv
tests/clockGen.sv
tests/colorMapperTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= colorMapperTb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
